//--- Makefile
# Verilator build and run of the pin-mux register block testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := tb_pinmux_reg
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/glbl_ctrl_regs.sv
/*
 * Global control registers
 * Chip ID, block reset control, global interrupt mask and status
 */
`include "pinmux_config.svh"

module glbl_ctrl_regs (
  input  logic                  mclk,
  input  logic                  h_reset_n,
  // Register access
  input  logic                  wr_stb,
  input  logic                  wr_ack_stb,
  input  pinmux_pkg::reg_ofs_t  reg_ofs,
  input  pinmux_pkg::reg_be_t   wr_be,
  input  pinmux_pkg::reg_data_t wr_data,
  output pinmux_pkg::reg_data_t glbl_rdata,
  // Hardware interrupt requests
  input  logic                  gpio_intr,
  input  logic [1:0]            ext_intr_in,
  input  logic                  usb_intr,
  input  logic                  i2cm_intr,
  input  logic [2:0]            timer_intr,
  // Block resets
  output logic [1:0]            cpu_core_rst_n,
  output logic                  cpu_intf_rst_n,
  output logic                  qspim_rst_n,
  output logic                  sspim_rst_n,
  output logic                  uart_rst_n,
  output logic                  i2cm_rst_n,
  output logic                  usb_rst_n,
  // CPU interrupts
  output logic [15:0]           irq_lines,
  output logic                  soft_irq,
  output logic [2:0]            user_irq
);
  import pinmux_pkg::*;

  localparam reg_data_t chip_id_word =
    {`CHIP_MANU_ID, `CHIP_TOTAL_CORE, `CHIP_ID, `CHIP_REV};

  glbl_ctrl_u                  glbl_ctrl;
  reg_data_t                   irq_mask;
  reg_data_t                   irq_stat;
  logic [7:0]                  stat_sw_lo;
  logic [`PINMUX_HW_IRQ_W-1:0] stat_hw;
  logic [3:0]                  stat_sw_hi;
  logic [`PINMUX_HW_IRQ_W-1:0] hw_req;
  logic [`PINMUX_HW_IRQ_W-1:0] hw_req_q;
  logic [`PINMUX_HW_IRQ_W-1:0] hw_clr;
  logic                        ctrl_sel;
  logic                        mask_sel;
  logic                        stat_sel;

  assign ctrl_sel = reg_ofs == `REG_GLBL_CTRL;
  assign mask_sel = reg_ofs == `REG_IRQ_MASK;
  assign stat_sel = reg_ofs == `REG_IRQ_STAT;

  // ------------------------------------------------
  // Reset control and interrupt mask
  // ------------------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      // All blocks held in reset
      glbl_ctrl.raw <= '0;
      irq_mask      <= '0;
    end else begin
      if (wr_stb && ctrl_sel) begin
        glbl_ctrl.raw <= be_merge(glbl_ctrl.raw, wr_data, wr_be);
      end
      if (wr_stb && mask_sel) begin
        irq_mask <= be_merge(irq_mask, wr_data, wr_be);
      end
    end
  end

  assign cpu_intf_rst_n = glbl_ctrl.f.cpu_intf;
  assign qspim_rst_n    = glbl_ctrl.f.qspim;
  assign sspim_rst_n    = glbl_ctrl.f.sspim;
  assign uart_rst_n     = glbl_ctrl.f.uart;
  assign i2cm_rst_n     = glbl_ctrl.f.i2cm;
  assign usb_rst_n      = glbl_ctrl.f.usb;
  assign cpu_core_rst_n = glbl_ctrl.f.cpu_core;

  // ------------------------------------------------
  // Interrupt status
  // ------------------------------------------------
  // Byte 1 sources, gpio at the top
  assign hw_req = {gpio_intr, ext_intr_in, usb_intr, i2cm_intr, timer_intr};
  // Write-1-to-clear, once per access
  assign hw_clr = {`PINMUX_HW_IRQ_W{wr_ack_stb & stat_sel & wr_be[1]}} & wr_data[15:8];

  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      hw_req_q   <= '0;
      stat_sw_lo <= '0;
      stat_hw    <= '0;
      stat_sw_hi <= '0;
    end else begin
      // Requests sampled first, latched an edge later
      hw_req_q <= hw_req;
      // New request beats a clear
      stat_hw  <= (stat_hw & ~hw_clr) | hw_req_q;
      if (wr_stb && stat_sel && wr_be[0]) begin
        stat_sw_lo <= wr_data[7:0];
      end
      if (wr_stb && stat_sel && wr_be[2]) begin
        stat_sw_hi <= wr_data[19:16];
      end
    end
  end

  // Upper 12 bits unimplemented
  assign irq_stat = {12'h000, stat_sw_hi, stat_hw, stat_sw_lo};

  assign irq_lines = irq_stat[15:0]  & irq_mask[15:0];
  assign soft_irq  = irq_stat[16]    & irq_mask[16];
  assign user_irq  = irq_stat[19:17] & irq_mask[19:17];

  // Read mux
  always_comb begin
    case (reg_ofs)
      `REG_CHIP_ID:   glbl_rdata = chip_id_word;
      `REG_GLBL_CTRL: glbl_rdata = glbl_ctrl.raw;
      `REG_IRQ_MASK:  glbl_rdata = irq_mask;
      `REG_IRQ_STAT:  glbl_rdata = irq_stat;
      default:        glbl_rdata = '0;
    endcase
  end

endmodule

//--- design/gpio_regs.sv
/*
 * GPIO registers
 * Input synchronizer, pin configuration and GPIO interrupt status/mask
 */
`include "pinmux_config.svh"

module gpio_regs (
  input  logic                  mclk,
  input  logic                  h_reset_n,
  // Register access
  input  logic                  wr_stb,
  input  logic                  wr_ack_stb,
  input  pinmux_pkg::reg_ofs_t  reg_ofs,
  input  pinmux_pkg::reg_be_t   wr_be,
  input  pinmux_pkg::reg_data_t wr_data,
  output pinmux_pkg::reg_data_t gpio_rdata,
  // Pin side
  input  pinmux_pkg::gpio_vec_t gpio_in_data,
  input  pinmux_pkg::gpio_vec_t gpio_int_event,
  // Configuration to GPIO control
  output pinmux_pkg::gpio_vec_t cfg_gpio_out_data,
  output pinmux_pkg::gpio_vec_t cfg_gpio_data_in,
  output pinmux_pkg::gpio_vec_t cfg_gpio_dir_sel,
  output pinmux_pkg::gpio_vec_t cfg_gpio_posedge_int_sel,
  output pinmux_pkg::gpio_vec_t cfg_gpio_negedge_int_sel,
  output pinmux_pkg::gpio_vec_t gpio_prev_indata,
  output logic                  gpio_intr
);
  import pinmux_pkg::*;

  gpio_vec_t gpio_in_s;
  gpio_vec_t gpio_in_ss;
  gpio_vec_t gpio_in_q;
  gpio_vec_t gpio_out;
  gpio_vec_t gpio_dir;
  gpio_vec_t gpio_imask;
  gpio_vec_t gpio_possel;
  gpio_vec_t gpio_negsel;
  gpio_vec_t gpio_istat;
  gpio_vec_t istat_clr;
  gpio_vec_t istat_set;

  // ------------------------------------------------
  // Input synchronizer
  // ------------------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      gpio_in_s  <= '0;
      gpio_in_ss <= '0;
      gpio_in_q  <= '0;
    end else begin
      gpio_in_s  <= gpio_in_data;
      gpio_in_ss <= gpio_in_s;
      // Extra stage so edge logic sees previous and current
      gpio_in_q  <= gpio_in_ss;
    end
  end

  assign cfg_gpio_data_in = gpio_in_q;
  assign gpio_prev_indata = gpio_in_ss;

  // ------------------------------------------------
  // Configuration registers
  // ------------------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      gpio_out    <= '0;
      gpio_dir    <= '0;
      gpio_imask  <= '0;
      gpio_possel <= '0;
      gpio_negsel <= '0;
    end else if (wr_stb) begin
      // Byte-enabled writes
      case (reg_ofs)
        `REG_GPIO_OUT:    gpio_out    <= be_merge(gpio_out, wr_data, wr_be);
        `REG_GPIO_DIR:    gpio_dir    <= be_merge(gpio_dir, wr_data, wr_be);
        `REG_GPIO_IMASK:  gpio_imask  <= be_merge(gpio_imask, wr_data, wr_be);
        `REG_GPIO_POSSEL: gpio_possel <= be_merge(gpio_possel, wr_data, wr_be);
        `REG_GPIO_NEGSEL: gpio_negsel <= be_merge(gpio_negsel, wr_data, wr_be);
        default: begin
        end
      endcase
    end
  end

  assign cfg_gpio_out_data        = gpio_out;
  assign cfg_gpio_dir_sel         = gpio_dir;
  assign cfg_gpio_posedge_int_sel = gpio_possel;
  assign cfg_gpio_negedge_int_sel = gpio_negsel;

  // ------------------------------------------------
  // Interrupt status
  // ------------------------------------------------
  // Write 1 to clear, per enabled byte
  assign istat_clr = {`PINMUX_GPIO_W{wr_ack_stb && reg_ofs == `REG_GPIO_ISTAT}}
                     & be_mask(wr_be) & wr_data;
  // Events plus software set alias
  assign istat_set = gpio_int_event
                     | ({`PINMUX_GPIO_W{wr_ack_stb && reg_ofs == `REG_GPIO_ISET}} & wr_data);

  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      gpio_istat <= '0;
    end else begin
      // Set wins over clear
      gpio_istat <= (gpio_istat & ~istat_clr) | istat_set;
    end
  end

  // Single line into global status
  assign gpio_intr = |(gpio_istat & gpio_imask);

  // Read mux
  always_comb begin
    case (reg_ofs)
      `REG_GPIO_IN:     gpio_rdata = gpio_in_q;
      `REG_GPIO_OUT:    gpio_rdata = gpio_out;
      `REG_GPIO_DIR:    gpio_rdata = gpio_dir;
      // Both aliases return status
      `REG_GPIO_ISTAT:  gpio_rdata = gpio_istat;
      `REG_GPIO_ISET:   gpio_rdata = gpio_istat;
      `REG_GPIO_IMASK:  gpio_rdata = gpio_imask;
      `REG_GPIO_POSSEL: gpio_rdata = gpio_possel;
      `REG_GPIO_NEGSEL: gpio_rdata = gpio_negsel;
      default:          gpio_rdata = '0;
    endcase
  end

endmodule

//--- design/pinmux_config.svh
/*
 * Pin-mux register block configuration
 * Bus widths, register word offsets and chip identification fields
 */
`ifndef PINMUX_CONFIG_SVH
`define PINMUX_CONFIG_SVH

// Bus and vector widths
`define PINMUX_DATA_W    32
`define PINMUX_BE_W      4
`define PINMUX_OFS_W     5
`define PINMUX_GPIO_W    32
`define PINMUX_HW_IRQ_W  8

// Register word offsets, gaps read zero
`define REG_CHIP_ID      5'd0
`define REG_GLBL_CTRL    5'd1
`define REG_IRQ_MASK     5'd3
`define REG_IRQ_STAT     5'd4
`define REG_GPIO_IN      5'd5
`define REG_GPIO_OUT     5'd6
`define REG_GPIO_DIR     5'd7
`define REG_GPIO_ISTAT   5'd9
`define REG_GPIO_ISET    5'd10
`define REG_GPIO_IMASK   5'd11
`define REG_GPIO_POSSEL  5'd12
`define REG_GPIO_NEGSEL  5'd13

// Chip ID word fields, MSB first
`define CHIP_MANU_ID     16'h8268
`define CHIP_TOTAL_CORE  4'd2
`define CHIP_ID          4'd3
`define CHIP_REV         8'h01

`endif

//--- design/pinmux_pkg.sv
/*
 * Pin-mux register types
 * Bus word types, reset-control layout and byte-enable helpers
 */
package pinmux_pkg;
  `include "pinmux_config.svh"

  typedef logic [`PINMUX_DATA_W-1:0] reg_data_t;
  typedef logic [`PINMUX_BE_W-1:0]   reg_be_t;
  typedef logic [`PINMUX_OFS_W-1:0]  reg_ofs_t;
  typedef logic [`PINMUX_GPIO_W-1:0] gpio_vec_t;

  // ------------------------------------------------
  // Reset-control word, 1 releases the block
  // ------------------------------------------------
  typedef struct packed {
    logic [21:0] rsvd_hi;
    logic [1:0]  cpu_core;
    logic [1:0]  rsvd_lo;
    logic        usb;
    logic        i2cm;
    logic        uart;
    logic        sspim;
    logic        qspim;
    logic        cpu_intf;
  } glbl_ctrl_fields_t;

  // Bus side sees raw word, reset outputs see fields
  typedef union packed {
    reg_data_t         raw;
    glbl_ctrl_fields_t f;
  } glbl_ctrl_u;

  // Byte enables widened to a bit mask
  function automatic reg_data_t be_mask(reg_be_t be);
    reg_data_t mask;
    for (int i = 0; i < `PINMUX_BE_W; i++) begin
      mask[i*8 +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

  // Replace only the enabled bytes
  function automatic reg_data_t be_merge(reg_data_t old_val, reg_data_t new_val, reg_be_t be);
    reg_data_t mask;
    mask = be_mask(be);
    return (old_val & ~mask) | (new_val & mask);
  endfunction
endpackage

//--- design/pinmux_reg.sv
/*
 * Pin-mux register block top
 * Bus slave feeding the global control and GPIO register groups
 */
module pinmux_reg (
  input  logic                  mclk,
  input  logic                  h_reset_n,
  // Register bus
  input  logic                  reg_cs,
  input  logic                  reg_wr,
  input  logic [7:0]            reg_addr,
  input  pinmux_pkg::reg_data_t reg_wdata,
  input  pinmux_pkg::reg_be_t   reg_be,
  output pinmux_pkg::reg_data_t reg_rdata,
  output logic                  reg_ack,
  // Block resets
  output logic [1:0]            cpu_core_rst_n,
  output logic                  cpu_intf_rst_n,
  output logic                  qspim_rst_n,
  output logic                  sspim_rst_n,
  output logic                  uart_rst_n,
  output logic                  i2cm_rst_n,
  output logic                  usb_rst_n,
  // Interrupts
  input  logic [1:0]            ext_intr_in,
  input  logic                  usb_intr,
  input  logic                  i2cm_intr,
  input  logic [2:0]            timer_intr,
  output logic [15:0]           irq_lines,
  output logic                  soft_irq,
  output logic [2:0]            user_irq,
  // GPIO
  input  pinmux_pkg::gpio_vec_t gpio_in_data,
  input  pinmux_pkg::gpio_vec_t gpio_int_event,
  output pinmux_pkg::gpio_vec_t cfg_gpio_out_data,
  output pinmux_pkg::gpio_vec_t cfg_gpio_data_in,
  output pinmux_pkg::gpio_vec_t cfg_gpio_dir_sel,
  output pinmux_pkg::gpio_vec_t cfg_gpio_posedge_int_sel,
  output pinmux_pkg::gpio_vec_t cfg_gpio_negedge_int_sel,
  output pinmux_pkg::gpio_vec_t gpio_prev_indata
);
  import pinmux_pkg::*;

  // Shared write path
  logic      wr_stb;
  logic      wr_ack_stb;
  reg_ofs_t  reg_ofs;
  reg_be_t   wr_be;
  reg_data_t wr_data;
  // Per-group read data
  reg_data_t glbl_rdata;
  reg_data_t gpio_rdata;
  // GPIO interrupt into global status
  logic      gpio_intr;

  reg_bus_slave u_bus (
    .mclk       (mclk),
    .h_reset_n  (h_reset_n),
    .reg_cs     (reg_cs),
    .reg_wr     (reg_wr),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_be     (reg_be),
    .reg_rdata  (reg_rdata),
    .reg_ack    (reg_ack),
    .glbl_rdata (glbl_rdata),
    .gpio_rdata (gpio_rdata),
    .wr_stb     (wr_stb),
    .wr_ack_stb (wr_ack_stb),
    .reg_ofs    (reg_ofs),
    .wr_be      (wr_be),
    .wr_data    (wr_data)
  );

  glbl_ctrl_regs u_glbl (
    .mclk           (mclk),
    .h_reset_n      (h_reset_n),
    .wr_stb         (wr_stb),
    .wr_ack_stb     (wr_ack_stb),
    .reg_ofs        (reg_ofs),
    .wr_be          (wr_be),
    .wr_data        (wr_data),
    .glbl_rdata     (glbl_rdata),
    .gpio_intr      (gpio_intr),
    .ext_intr_in    (ext_intr_in),
    .usb_intr       (usb_intr),
    .i2cm_intr      (i2cm_intr),
    .timer_intr     (timer_intr),
    .cpu_core_rst_n (cpu_core_rst_n),
    .cpu_intf_rst_n (cpu_intf_rst_n),
    .qspim_rst_n    (qspim_rst_n),
    .sspim_rst_n    (sspim_rst_n),
    .uart_rst_n     (uart_rst_n),
    .i2cm_rst_n     (i2cm_rst_n),
    .usb_rst_n      (usb_rst_n),
    .irq_lines      (irq_lines),
    .soft_irq       (soft_irq),
    .user_irq       (user_irq)
  );

  gpio_regs u_gpio (
    .mclk                     (mclk),
    .h_reset_n                (h_reset_n),
    .wr_stb                   (wr_stb),
    .wr_ack_stb               (wr_ack_stb),
    .reg_ofs                  (reg_ofs),
    .wr_be                    (wr_be),
    .wr_data                  (wr_data),
    .gpio_rdata               (gpio_rdata),
    .gpio_in_data             (gpio_in_data),
    .gpio_int_event           (gpio_int_event),
    .cfg_gpio_out_data        (cfg_gpio_out_data),
    .cfg_gpio_data_in         (cfg_gpio_data_in),
    .cfg_gpio_dir_sel         (cfg_gpio_dir_sel),
    .cfg_gpio_posedge_int_sel (cfg_gpio_posedge_int_sel),
    .cfg_gpio_negedge_int_sel (cfg_gpio_negedge_int_sel),
    .gpio_prev_indata         (gpio_prev_indata),
    .gpio_intr                (gpio_intr)
  );

endmodule

//--- design/reg_bus_slave.sv
/*
 * Register bus slave
 * One-cycle acknowledge, write strobes and registered read-data merge
 */
`include "pinmux_config.svh"

module reg_bus_slave (
  input  logic                 mclk,
  input  logic                 h_reset_n,
  // Master side
  input  logic                 reg_cs,
  input  logic                 reg_wr,
  input  logic [7:0]           reg_addr,
  input  pinmux_pkg::reg_data_t reg_wdata,
  input  pinmux_pkg::reg_be_t   reg_be,
  output pinmux_pkg::reg_data_t reg_rdata,
  output logic                 reg_ack,
  // Register group side
  input  pinmux_pkg::reg_data_t glbl_rdata,
  input  pinmux_pkg::reg_data_t gpio_rdata,
  output logic                 wr_stb,
  output logic                 wr_ack_stb,
  output pinmux_pkg::reg_ofs_t  reg_ofs,
  output pinmux_pkg::reg_be_t   wr_be,
  output pinmux_pkg::reg_data_t wr_data
);
  import pinmux_pkg::*;

  reg_data_t rdata_mux;
  logic      ack_set;

  // ------------------------------------------------
  // Decode
  // ------------------------------------------------
  // Byte address to word offset
  assign reg_ofs = reg_addr[`PINMUX_OFS_W+1:2];
  assign wr_be   = reg_be;
  assign wr_data = reg_wdata;

  // Held over request and ack cycles
  assign wr_stb     = reg_cs & reg_wr;
  // Ack cycle only, for one-shot set/clear
  assign wr_ack_stb = reg_cs & reg_wr & reg_ack;

  // Groups return zero outside their offsets
  assign rdata_mux = glbl_rdata | gpio_rdata;

  // First cycle of a request
  assign ack_set = reg_cs & ~reg_ack;

  // ------------------------------------------------
  // Handshake
  // ------------------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      reg_ack <= 1'b0;
    end else begin
      // Single-cycle pulse, master drops cs after it
      reg_ack <= ack_set;
    end
  end

  // Read data captured with the ack
  always_ff @(posedge mclk) begin
    if (ack_set) begin
      reg_rdata <= rdata_mux;
    end
  end

endmodule

//--- list.f
+incdir+design
design/pinmux_pkg.sv
design/reg_bus_slave.sv
design/glbl_ctrl_regs.sv
design/gpio_regs.sv
design/pinmux_reg.sv
verification/tb_pinmux_reg.sv

//--- verification/tb_pinmux_reg.sv
/*
 * Pin-mux register block testbench
 * Directed bus tests of ID, reset control, interrupts and GPIO registers
 */
module tb_pinmux_reg;

  // Word offsets
  localparam logic [4:0] ofs_chip_id     = 5'd0;
  localparam logic [4:0] ofs_glbl_ctrl   = 5'd1;
  localparam logic [4:0] ofs_dropped     = 5'd2;
  localparam logic [4:0] ofs_irq_mask    = 5'd3;
  localparam logic [4:0] ofs_irq_stat    = 5'd4;
  localparam logic [4:0] ofs_gpio_in     = 5'd5;
  localparam logic [4:0] ofs_gpio_out    = 5'd6;
  localparam logic [4:0] ofs_gpio_dir    = 5'd7;
  localparam logic [4:0] ofs_gpio_istat  = 5'd9;
  localparam logic [4:0] ofs_gpio_iset   = 5'd10;
  localparam logic [4:0] ofs_gpio_imask  = 5'd11;
  localparam logic [4:0] ofs_gpio_possel = 5'd12;
  localparam logic [4:0] ofs_gpio_negsel = 5'd13;
  // Manufacturer, core count, chip, revision
  localparam logic [31:0] chip_id_word   = {16'h8268, 4'h2, 4'h3, 8'h01};
  localparam int          ack_timeout    = 16;

  logic        mclk = 1'b0;
  logic        h_reset_n;
  logic        reg_cs;
  logic        reg_wr;
  logic [7:0]  reg_addr;
  logic [31:0] reg_wdata;
  logic [3:0]  reg_be;
  logic [31:0] reg_rdata;
  logic        reg_ack;
  logic [1:0]  cpu_core_rst_n;
  logic        cpu_intf_rst_n;
  logic        qspim_rst_n;
  logic        sspim_rst_n;
  logic        uart_rst_n;
  logic        i2cm_rst_n;
  logic        usb_rst_n;
  logic [1:0]  ext_intr_in;
  logic        usb_intr;
  logic        i2cm_intr;
  logic [2:0]  timer_intr;
  logic [15:0] irq_lines;
  logic        soft_irq;
  logic [2:0]  user_irq;
  logic [31:0] gpio_in_data;
  logic [31:0] gpio_int_event;
  logic [31:0] cfg_gpio_out_data;
  logic [31:0] cfg_gpio_data_in;
  logic [31:0] cfg_gpio_dir_sel;
  logic [31:0] cfg_gpio_posedge_int_sel;
  logic [31:0] cfg_gpio_negedge_int_sel;
  logic [31:0] gpio_prev_indata;

  int          mismatches;
  int          timeouts;
  int          ack_cycles;
  logic [31:0] lfsr_state;
  // Expected register contents
  logic [31:0] ctrl_model;
  logic [31:0] mask_model;
  logic [31:0] stat_model;

  pinmux_reg DUT (.*);

  always #20 mclk = ~mclk;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    mismatches++;
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  task automatic next_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
  endtask

  // Old word with enabled bytes taken from new
  function automatic logic [31:0] apply_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // --------------------------------------------------
  // Bus master
  // --------------------------------------------------
  task automatic bus_access(input logic wr, input logic [4:0] ofs, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata);
    int waited;
    @(posedge mclk);
    #2;
    reg_cs    = 1'b1;
    reg_wr    = wr;
    reg_addr  = {1'b0, ofs, 2'b00};
    reg_wdata = wdata;
    reg_be    = be;
    waited    = 0;
    // Ack looked at just after each edge
    while (!reg_ack && waited < ack_timeout) begin
      @(posedge mclk);
      #2;
      waited++;
    end
    ack_cycles = waited;
    if (!reg_ack) begin
      timeouts++;
      $display("Timeout at %0t: no reg_ack within %0d cycles, offset %0d",
               $time, ack_timeout, ofs);
    end
    rdata = reg_rdata;
    // Request held across the ack edge
    @(posedge mclk);
    #2;
    reg_cs = 1'b0;
    reg_wr = 1'b0;
  endtask

  task automatic bus_write(input logic [4:0] ofs, input logic [31:0] data,
                           input logic [3:0] be);
    logic [31:0] unused_rd;
    bus_access(1'b1, ofs, data, be, unused_rd);
  endtask

  task automatic read_expect(input logic [4:0] ofs, input logic [31:0] exp,
                             input string name);
    logic [31:0] rd;
    bus_access(1'b0, ofs, 32'h0, 4'hf, rd);
    if (rd !== exp) report_mismatch(name, rd, exp);
  endtask

  // Reset outputs against the control word
  task automatic check_resets();
    logic [7:0] got;
    got = {cpu_core_rst_n, usb_rst_n, i2cm_rst_n, uart_rst_n, sspim_rst_n,
           qspim_rst_n, cpu_intf_rst_n};
    if (got !== {ctrl_model[9:8], ctrl_model[5:0]})
      report_mismatch("reset outputs", {24'h0, got}, {24'h0, ctrl_model[9:8], ctrl_model[5:0]});
  endtask

  // Interrupt outputs are status AND mask
  task automatic check_irqs();
    logic [31:0] en;
    en = stat_model & mask_model;
    if (irq_lines !== en[15:0])
      report_mismatch("irq_lines", {16'h0, irq_lines}, {16'h0, en[15:0]});
    if (soft_irq !== en[16])
      report_mismatch("soft_irq", {31'h0, soft_irq}, {31'h0, en[16]});
    if (user_irq !== en[19:17])
      report_mismatch("user_irq", {29'h0, user_irq}, {29'h0, en[19:17]});
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_reset_and_id();
    check_resets();
    check_irqs();
    if (cfg_gpio_out_data !== 32'h0) report_mismatch("cfg_gpio_out_data", cfg_gpio_out_data, 0);
    if (cfg_gpio_dir_sel !== 32'h0) report_mismatch("cfg_gpio_dir_sel", cfg_gpio_dir_sel, 0);
    read_expect(ofs_chip_id, chip_id_word, "chip_id");
    // Ack one cycle after select and for one cycle only
    if (ack_cycles != 1) report_mismatch("reg_ack latency", ack_cycles, 1);
    if (reg_ack !== 1'b0) report_mismatch("reg_ack after ack cycle", {31'h0, reg_ack}, 0);
    bus_write(ofs_dropped, 32'hffff_ffff, 4'hf);
    read_expect(ofs_dropped, 32'h0, "dropped offset 2");
    read_expect(5'd20, 32'h0, "dropped offset 20");
  endtask

  task automatic test_reset_ctrl();
    logic [3:0]  be_list [5];
    logic [31:0] word;
    be_list = '{4'b1111, 4'b0001, 4'b0110, 4'b1000, 4'b0011};
    foreach (be_list[i]) begin
      next_word(word);
      bus_write(ofs_glbl_ctrl, word, be_list[i]);
      ctrl_model = apply_bytes(ctrl_model, word, be_list[i]);
      read_expect(ofs_glbl_ctrl, ctrl_model, "glbl_ctrl");
      check_resets();
    end
  endtask

  task automatic test_global_irq();
    logic [31:0] word;
    // One-cycle pulse on usb and timer 2/0
    usb_intr   = 1'b1;
    timer_intr = 3'b101;
    @(posedge mclk);
    #2;
    usb_intr   = 1'b0;
    timer_intr = 3'b000;
    stat_model[12] = 1'b1;
    stat_model[10] = 1'b1;
    stat_model[8]  = 1'b1;
    read_expect(ofs_irq_stat, stat_model, "irq_stat after pulse");
    check_irqs();
    next_word(word);
    mask_model = word | 32'h000a_1000;
    bus_write(ofs_irq_mask, mask_model, 4'hf);
    read_expect(ofs_irq_mask, mask_model, "irq_mask");
    check_irqs();
    // Write 1 clears timer 0 only
    bus_write(ofs_irq_stat, 32'h0000_0100, 4'b0010);
    stat_model[8] = 1'b0;
    read_expect(ofs_irq_stat, stat_model, "irq_stat after clear");
    check_irqs();
    // Software byte 0 and bits 16-19
    // Top nibble of byte 2 reads zero
    next_word(word);
    bus_write(ofs_irq_stat, word | 32'h000f_0000, 4'b0101);
    stat_model[7:0]   = word[7:0];
    stat_model[19:16] = 4'hf;
    read_expect(ofs_irq_stat, stat_model, "irq_stat software bits");
    check_irqs();
  endtask

  task automatic test_gpio_cfg();
    logic [31:0] word;
    logic [31:0] exp;
    next_word(word);
    bus_write(ofs_gpio_out, word, 4'b1111);
    if (cfg_gpio_out_data !== word) report_mismatch("cfg_gpio_out_data", cfg_gpio_out_data, word);
    read_expect(ofs_gpio_out, word, "gpio_out");
    next_word(word);
    bus_write(ofs_gpio_dir, word, 4'b0110);
    exp = apply_bytes(32'h0, word, 4'b0110);
    if (cfg_gpio_dir_sel !== exp) report_mismatch("cfg_gpio_dir_sel", cfg_gpio_dir_sel, exp);
    read_expect(ofs_gpio_dir, exp, "gpio_dir");
    next_word(word);
    bus_write(ofs_gpio_possel, word, 4'b1111);
    if (cfg_gpio_posedge_int_sel !== word)
      report_mismatch("cfg_gpio_posedge_int_sel", cfg_gpio_posedge_int_sel, word);
    read_expect(ofs_gpio_possel, word, "gpio_possel");
    next_word(word);
    bus_write(ofs_gpio_negsel, word, 4'b1001);
    exp = apply_bytes(32'h0, word, 4'b1001);
    if (cfg_gpio_negedge_int_sel !== exp)
      report_mismatch("cfg_gpio_negedge_int_sel", cfg_gpio_negedge_int_sel, exp);
    read_expect(ofs_gpio_negsel, exp, "gpio_negsel");
    // New input through the synchronizer
    next_word(word);
    gpio_in_data = word;
    repeat (2) begin
      @(posedge mclk);
      #2;
    end
    if (gpio_prev_indata !== word) report_mismatch("gpio_prev_indata", gpio_prev_indata, word);
    if (cfg_gpio_data_in !== 32'h0) report_mismatch("cfg_gpio_data_in early", cfg_gpio_data_in, 0);
    @(posedge mclk);
    #2;
    if (cfg_gpio_data_in !== word) report_mismatch("cfg_gpio_data_in", cfg_gpio_data_in, word);
    read_expect(ofs_gpio_in, word, "gpio_in");
  endtask

  task automatic test_gpio_irq();
    logic [31:0] istat;
    gpio_int_event = 32'h0000_00f0;
    @(posedge mclk);
    #2;
    gpio_int_event = 32'h0;
    bus_write(ofs_gpio_iset, 32'h8100_5500, 4'hf);
    istat = 32'h8100_55f0;
    read_expect(ofs_gpio_istat, istat, "gpio_istat");
    read_expect(ofs_gpio_iset, istat, "gpio_iset alias");
    // Mask still zero
    if (DUT.u_gpio.gpio_intr !== 1'b0)
      report_mismatch("gpio_intr unmasked", {31'h0, DUT.u_gpio.gpio_intr}, 0);
    read_expect(ofs_irq_stat, stat_model, "irq_stat before gpio mask");
    bus_write(ofs_gpio_imask, 32'h0000_0010, 4'hf);
    read_expect(ofs_gpio_imask, 32'h0000_0010, "gpio_imask");
    if (DUT.u_gpio.gpio_intr !== 1'b1)
      report_mismatch("gpio_intr masked in", {31'h0, DUT.u_gpio.gpio_intr}, 1);
    stat_model[15] = 1'b1;
    read_expect(ofs_irq_stat, stat_model, "irq_stat gpio bit");
    check_irqs();
    // Top byte cleared under byte enable 3
    bus_write(ofs_gpio_istat, 32'hffff_ffff, 4'b1000);
    istat[31:24] = 8'h00;
    read_expect(ofs_gpio_istat, istat, "gpio_istat byte 3 clear");
    // Byte 1 ones ignored without its enable
    bus_write(ofs_gpio_istat, 32'h0000_ff30, 4'b0001);
    istat = istat & ~32'h0000_0030;
    read_expect(ofs_gpio_istat, istat, "gpio_istat byte 0 clear");
    if (DUT.u_gpio.gpio_intr !== 1'b0)
      report_mismatch("gpio_intr after clear", {31'h0, DUT.u_gpio.gpio_intr}, 0);
    bus_write(ofs_irq_stat, 32'h0000_8000, 4'b0010);
    stat_model[15] = 1'b0;
    read_expect(ofs_irq_stat, stat_model, "irq_stat gpio bit clear");
    check_irqs();
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    h_reset_n      = 1'b0;
    reg_cs         = 1'b0;
    reg_wr         = 1'b0;
    reg_addr       = 8'h00;
    reg_wdata      = 32'h0;
    reg_be         = 4'h0;
    ext_intr_in    = 2'b00;
    usb_intr       = 1'b0;
    i2cm_intr      = 1'b0;
    timer_intr     = 3'b000;
    gpio_in_data   = 32'h0;
    gpio_int_event = 32'h0;
    mismatches     = 0;
    timeouts       = 0;
    ack_cycles     = 0;
    lfsr_state     = 32'h4dc5;
    ctrl_model     = 32'h0;
    mask_model     = 32'h0;
    stat_model     = 32'h0;
    repeat (4) @(posedge mclk);
    #2;
    h_reset_n = 1'b1;

    test_reset_and_id();
    test_reset_ctrl();
    test_global_irq();
    test_gpio_cfg();
    test_gpio_irq();

    $display("Mismatches: %0d, timeouts: %0d", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
